// File: dc_cfg.svh
`ifndef DC_CFG_SVH
`define DC_CFG_SVH

// Physical address and data widths
`define DC_ADDR_W 32
`define DC_XLEN 64

// Request offset covers one 64-byte line
`define DC_OFFSET_W 6
`define DC_TAG_W (`DC_ADDR_W - `DC_OFFSET_W)

// Back-end depth in 64-bit words
`define DC_MEM_WORDS 64

// Cacheable byte range, everything above is uncacheable
`define DC_CACHEABLE_BASE 32'h0000_0000
`define DC_CACHEABLE_SIZE 32'h0000_0100

// Transaction and source ID widths
`define DC_TID_W 4
`define DC_SID_W 1

`endif

// File: dc_pkg.sv
`include "dc_cfg.svh"

package dc_pkg;

  // Cache request opcodes
  typedef enum logic [3:0] {
    DC_OP_LOAD,
    DC_OP_STORE,
    DC_OP_AMO_LR,
    DC_OP_AMO_SC,
    DC_OP_AMO_SWAP,
    DC_OP_AMO_ADD,
    DC_OP_AMO_AND,
    DC_OP_AMO_OR,
    DC_OP_AMO_XOR,
    DC_OP_AMO_MAX,
    DC_OP_AMO_MAXU,
    DC_OP_AMO_MIN,
    DC_OP_AMO_MINU
  } dc_op_e;

  // AMO opcodes as the core encodes them
  typedef enum logic [3:0] {
    AMO_NONE = 4'b0000,
    AMO_LR   = 4'b0001,
    AMO_SC   = 4'b0010,
    AMO_SWAP = 4'b0011,
    AMO_ADD  = 4'b0100,
    AMO_AND  = 4'b0101,
    AMO_OR   = 4'b0110,
    AMO_XOR  = 4'b0111,
    AMO_MAX  = 4'b1000,
    AMO_MAXU = 4'b1001,
    AMO_MIN  = 4'b1010,
    AMO_MINU = 4'b1011
  } core_amo_e;

  typedef struct packed {
    logic uncacheable;
  } dc_pma_t;

  typedef struct packed {
    logic [`DC_OFFSET_W-1:0] addr_offset;
    logic [`DC_TAG_W-1:0]    addr_tag;
    logic [`DC_XLEN-1:0]     wdata;
    logic [`DC_XLEN/8-1:0]   be;
    logic [1:0]              size;
    dc_op_e                  op;
    logic [`DC_SID_W-1:0]    sid;
    logic [`DC_TID_W-1:0]    tid;
    logic                    need_rsp;
    dc_pma_t                 pma;
  } dc_req_t;

  typedef struct packed {
    logic [`DC_XLEN-1:0]  rdata;
    logic [`DC_SID_W-1:0] sid;
    logic [`DC_TID_W-1:0] tid;
  } dc_rsp_t;

  // All-ones tid marks the single AMO in flight
  localparam logic [`DC_TID_W-1:0] DC_AMO_TID = '1;

  // Source IDs of the two adapters
  localparam logic [`DC_SID_W-1:0] DC_SID_LOAD  = 1'b0;
  localparam logic [`DC_SID_W-1:0] DC_SID_STAMO = 1'b1;

  // Region check on the line-aligned address of a tag
  function automatic logic dc_is_uncacheable(input logic [`DC_TAG_W-1:0] tag);
    logic [`DC_ADDR_W-1:0] addr;
    addr = {tag, {`DC_OFFSET_W{1'b0}}};
    return !((addr >= `DC_CACHEABLE_BASE) &&
             (addr < (`DC_CACHEABLE_BASE + `DC_CACHEABLE_SIZE)));
  endfunction

endpackage

// File: dc_port_if.sv
`timescale 1ns/1ps

interface dc_port_if;

  // Request channel
  logic             req_valid;
  logic             req_ready;
  dc_pkg::dc_req_t  req;
  logic             req_abort;

  // Response strobe, no back-pressure
  logic             rsp_valid;
  dc_pkg::dc_rsp_t  rsp;

  modport master (
    output req_valid,
    output req,
    output req_abort,
    input  req_ready,
    input  rsp_valid,
    input  rsp
  );

  modport slave (
    input  req_valid,
    input  req,
    input  req_abort,
    output req_ready,
    output rsp_valid,
    output rsp
  );

endinterface

// File: load_port_adapter.sv
`timescale 1ns/1ps
`include "dc_cfg.svh"

module load_port_adapter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  core_req_i,
  input  logic [`DC_ADDR_W-1:0] core_addr_i,
  input  logic [`DC_XLEN/8-1:0] core_be_i,
  input  logic [1:0]            core_size_i,
  input  logic [`DC_TID_W-1:0]  core_id_i,
  input  logic                  core_kill_i,
  output logic                  core_gnt_o,
  output logic                  core_rvalid_o,
  output logic [`DC_XLEN-1:0]   core_rdata_o,
  output logic [`DC_TID_W-1:0]  core_rid_o,
  dc_port_if.master             cache
);

  // Load request with the tag known in the same cycle
  assign cache.req_valid          = core_req_i;
  assign cache.req.addr_offset    = core_addr_i[`DC_OFFSET_W-1:0];
  assign cache.req.addr_tag       = core_addr_i[`DC_ADDR_W-1:`DC_OFFSET_W];
  assign cache.req.wdata          = '0;
  assign cache.req.be             = core_be_i;
  assign cache.req.size           = core_size_i;
  assign cache.req.op             = dc_pkg::DC_OP_LOAD;
  assign cache.req.sid            = dc_pkg::DC_SID_LOAD;
  assign cache.req.tid            = core_id_i;
  assign cache.req.need_rsp       = 1'b1;
  assign cache.req.pma.uncacheable =
      dc_pkg::dc_is_uncacheable(core_addr_i[`DC_ADDR_W-1:`DC_OFFSET_W]);
  assign cache.req_abort          = core_kill_i;

  assign core_gnt_o    = core_req_i & cache.req_ready;
  assign core_rvalid_o = cache.rsp_valid;
  assign core_rdata_o  = cache.rsp.rdata;
  assign core_rid_o    = cache.rsp.tid;

endmodule

// File: store_amo_port_adapter.sv
`timescale 1ns/1ps
`include "dc_cfg.svh"

module store_amo_port_adapter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Store port
  input  logic                  st_req_i,
  input  logic [`DC_ADDR_W-1:0] st_addr_i,
  input  logic [`DC_XLEN-1:0]   st_wdata_i,
  input  logic [`DC_XLEN/8-1:0] st_be_i,
  input  logic [1:0]            st_size_i,
  output logic                  st_gnt_o,
  // AMO port
  input  logic                  amo_req_i,
  input  dc_pkg::core_amo_e     amo_op_i,
  input  logic [1:0]            amo_size_i,
  input  logic [`DC_XLEN-1:0]   amo_operand_a_i,
  input  logic [`DC_XLEN-1:0]   amo_operand_b_i,
  output logic                  amo_ack_o,
  output logic [`DC_XLEN-1:0]   amo_result_o,
  dc_port_if.master             cache
);

  logic [`DC_ADDR_W-1:0] amo_addr;
  logic [`DC_ADDR_W-1:0] req_addr;
  dc_pkg::dc_op_e        amo_op;
  logic                  amo_is_word;
  logic                  amo_is_hi;
  logic [`DC_XLEN-1:0]   amo_data;
  logic [`DC_XLEN/8-1:0] amo_be;
  logic                  amo_sel;
  logic                  amo_pending_q;
  logic                  rsp_word_q;
  logic                  rsp_hi_q;
  logic [31:0]           rsp_half;

  assign amo_addr    = amo_operand_a_i[`DC_ADDR_W-1:0];
  assign amo_is_word = (amo_size_i == 2'b10);
  assign amo_is_hi   = amo_addr[2];

  // Core AMO encoding to cache opcode
  always_comb begin
    case (amo_op_i)
      dc_pkg::AMO_LR:   amo_op = dc_pkg::DC_OP_AMO_LR;
      dc_pkg::AMO_SC:   amo_op = dc_pkg::DC_OP_AMO_SC;
      dc_pkg::AMO_SWAP: amo_op = dc_pkg::DC_OP_AMO_SWAP;
      dc_pkg::AMO_ADD:  amo_op = dc_pkg::DC_OP_AMO_ADD;
      dc_pkg::AMO_AND:  amo_op = dc_pkg::DC_OP_AMO_AND;
      dc_pkg::AMO_OR:   amo_op = dc_pkg::DC_OP_AMO_OR;
      dc_pkg::AMO_XOR:  amo_op = dc_pkg::DC_OP_AMO_XOR;
      dc_pkg::AMO_MAX:  amo_op = dc_pkg::DC_OP_AMO_MAX;
      dc_pkg::AMO_MAXU: amo_op = dc_pkg::DC_OP_AMO_MAXU;
      dc_pkg::AMO_MIN:  amo_op = dc_pkg::DC_OP_AMO_MIN;
      dc_pkg::AMO_MINU: amo_op = dc_pkg::DC_OP_AMO_MINU;
      default:          amo_op = dc_pkg::DC_OP_LOAD;
    endcase
  end

  // Word data goes to both halves, the byte enable picks one
  assign amo_data = amo_is_word ? {2{amo_operand_b_i[31:0]}} : amo_operand_b_i;
  assign amo_be   = (amo_is_word && amo_is_hi) ? 8'hf0 :
                    amo_is_word                ? 8'h0f : 8'hff;

  // Only one AMO at a time
  assign amo_sel  = amo_req_i & ~amo_pending_q;
  assign req_addr = amo_sel ? amo_addr : st_addr_i;

  assign cache.req_valid        = st_req_i | amo_sel;
  assign cache.req.addr_offset  = req_addr[`DC_OFFSET_W-1:0];
  assign cache.req.addr_tag     = req_addr[`DC_ADDR_W-1:`DC_OFFSET_W];
  assign cache.req.wdata        = amo_sel ? amo_data : st_wdata_i;
  assign cache.req.be           = amo_sel ? amo_be : st_be_i;
  assign cache.req.size         = amo_sel ? amo_size_i : st_size_i;
  assign cache.req.op           = amo_sel ? amo_op : dc_pkg::DC_OP_STORE;
  assign cache.req.sid          = dc_pkg::DC_SID_STAMO;
  assign cache.req.tid          = amo_sel ? dc_pkg::DC_AMO_TID : '0;
  assign cache.req.need_rsp     = amo_sel;
  assign cache.req.pma.uncacheable =
      dc_pkg::dc_is_uncacheable(req_addr[`DC_ADDR_W-1:`DC_OFFSET_W]);
  assign cache.req_abort        = 1'b0;

  assign st_gnt_o = st_req_i & cache.req_ready & ~amo_sel;

  // Pending from transfer until ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      amo_pending_q <= 1'b0;
    end else if (amo_sel && cache.req_ready) begin
      amo_pending_q <= 1'b1;
    end else if (amo_ack_o) begin
      amo_pending_q <= 1'b0;
    end
  end

  // Half-select of the result, kept in case the core moves its operands
  always_ff @(posedge clk_i) begin
    if (amo_sel && cache.req_ready) begin
      rsp_word_q <= amo_is_word;
      rsp_hi_q   <= amo_is_hi;
    end
  end

  assign amo_ack_o = cache.rsp_valid & amo_pending_q & (cache.rsp.tid == dc_pkg::DC_AMO_TID);
  assign rsp_half  = rsp_hi_q ? cache.rsp.rdata[63:32] : cache.rsp.rdata[31:0];

  // Word results are sign-extended
  assign amo_result_o = rsp_word_q ? {{32{rsp_half[31]}}, rsp_half} : cache.rsp.rdata;

endmodule

// File: dc_port_arbiter.sv
`timescale 1ns/1ps

module dc_port_arbiter (
  input  logic      clk_i,
  input  logic      rst_ni,
  dc_port_if.slave  hi,
  dc_port_if.slave  lo,
  dc_port_if.master out
);

  // Store/AMO side always wins
  assign out.req_valid = hi.req_valid | lo.req_valid;
  assign out.req       = hi.req_valid ? hi.req : lo.req;
  assign out.req_abort = ~hi.req_valid & lo.req_abort;

  assign hi.req_ready = out.req_ready;
  assign lo.req_ready = out.req_ready & ~hi.req_valid;

  // Responses steered back by source ID
  assign hi.rsp = out.rsp;
  assign lo.rsp = out.rsp;
  assign hi.rsp_valid = out.rsp_valid & (out.rsp.sid == dc_pkg::DC_SID_STAMO);
  assign lo.rsp_valid = out.rsp_valid & (out.rsp.sid == dc_pkg::DC_SID_LOAD);

endmodule

// File: dc_backend.sv
`timescale 1ns/1ps
`include "dc_cfg.svh"

module dc_backend (
  input  logic     clk_i,
  input  logic     rst_ni,
  dc_port_if.slave port
);

  localparam int IdxW = $clog2(`DC_MEM_WORDS);

  logic [`DC_XLEN-1:0]   mem [`DC_MEM_WORDS];
  logic                  ready_q;
  logic                  xfer;
  logic [`DC_ADDR_W-1:0] addr;
  logic [IdxW-1:0]       idx;
  logic [`DC_XLEN-1:0]   old_word;
  logic [`DC_XLEN-1:0]   bmask;
  logic                  is_word;
  logic                  is_hi;
  logic                  is_signed;
  logic [31:0]           a_half;
  logic [31:0]           b_half;
  logic [`DC_XLEN-1:0]   a_op;
  logic [`DC_XLEN-1:0]   b_op;
  logic [`DC_XLEN-1:0]   alu_res;
  logic [`DC_XLEN-1:0]   new_word;
  logic [`DC_XLEN-1:0]   rdata_d;
  logic                  wr_en;
  logic                  sc_ok;
  logic                  resv_valid_q;
  logic [IdxW-1:0]       resv_idx_q;
  logic                  rsp_valid_q;
  dc_pkg::dc_rsp_t       rsp_q;

  function automatic logic [`DC_XLEN-1:0] amo_alu(input dc_pkg::dc_op_e op,
                                                  input logic [`DC_XLEN-1:0] a,
                                                  input logic [`DC_XLEN-1:0] b);
    case (op)
      dc_pkg::DC_OP_AMO_ADD:  return a + b;
      dc_pkg::DC_OP_AMO_AND:  return a & b;
      dc_pkg::DC_OP_AMO_OR:   return a | b;
      dc_pkg::DC_OP_AMO_XOR:  return a ^ b;
      dc_pkg::DC_OP_AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
      dc_pkg::DC_OP_AMO_MAXU: return (a > b) ? a : b;
      dc_pkg::DC_OP_AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      dc_pkg::DC_OP_AMO_MINU: return (a < b) ? a : b;
      default:                return b;
    endcase
  endfunction

  assign xfer = port.req_valid & ready_q;
  assign addr = {port.req.addr_tag, port.req.addr_offset};
  assign idx  = addr[3 +: IdxW];
  assign old_word = mem[idx];

  always_comb begin
    for (int i = 0; i < `DC_XLEN/8; i++) begin
      bmask[8*i +: 8] = {8{port.req.be[i]}};
    end
  end

  // Operands of a word AMO are extended from the selected half
  assign is_word   = (port.req.size == 2'b10);
  assign is_hi     = addr[2];
  assign is_signed = (port.req.op == dc_pkg::DC_OP_AMO_MAX) ||
                     (port.req.op == dc_pkg::DC_OP_AMO_MIN);
  assign a_half    = is_hi ? old_word[63:32] : old_word[31:0];
  assign b_half    = is_hi ? port.req.wdata[63:32] : port.req.wdata[31:0];

  always_comb begin
    if (is_word) begin
      a_op = is_signed ? {{32{a_half[31]}}, a_half} : {32'b0, a_half};
      b_op = is_signed ? {{32{b_half[31]}}, b_half} : {32'b0, b_half};
    end else begin
      a_op = old_word;
      b_op = port.req.wdata;
    end
  end

  assign alu_res = amo_alu(port.req.op, a_op, b_op);
  assign sc_ok   = resv_valid_q && (resv_idx_q == idx);

  always_comb begin
    wr_en    = 1'b0;
    new_word = port.req.wdata;
    rdata_d  = old_word;
    case (port.req.op)
      dc_pkg::DC_OP_LOAD, dc_pkg::DC_OP_AMO_LR: begin
        wr_en = 1'b0;
      end
      dc_pkg::DC_OP_STORE: begin
        wr_en = 1'b1;
      end
      dc_pkg::DC_OP_AMO_SC: begin
        wr_en   = sc_ok;
        // 0 on success and 1 on failure, in both halves for a word
        rdata_d = is_word ? {2{31'b0, ~sc_ok}} : {63'b0, ~sc_ok};
      end
      default: begin
        wr_en    = 1'b1;
        new_word = is_word ? {2{alu_res[31:0]}} : alu_res;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `DC_MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (xfer && wr_en) begin
      mem[idx] <= (old_word & ~bmask) | (new_word & bmask);
    end
  end

  // LR/SC reservation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_valid_q <= 1'b0;
      resv_idx_q   <= '0;
    end else if (xfer) begin
      if (port.req.op == dc_pkg::DC_OP_AMO_LR) begin
        resv_valid_q <= ~port.req.pma.uncacheable;
        resv_idx_q   <= idx;
      end else if (port.req.op == dc_pkg::DC_OP_AMO_SC) begin
        resv_valid_q <= 1'b0;
      end else if (port.req.op != dc_pkg::DC_OP_LOAD && idx == resv_idx_q) begin
        resv_valid_q <= 1'b0;
      end
    end
  end

  // Always ready once out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      ready_q     <= 1'b1;
      rsp_valid_q <= xfer & port.req.need_rsp & ~port.req_abort;
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rsp_q.rdata <= rdata_d;
      rsp_q.sid   <= port.req.sid;
      rsp_q.tid   <= port.req.tid;
    end
  end

  assign port.req_ready = ready_q;
  assign port.rsp_valid = rsp_valid_q;
  assign port.rsp       = rsp_q;

endmodule

// File: dc_subsys_top.sv
`timescale 1ns/1ps
`include "dc_cfg.svh"

module dc_subsys_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Load port
  input  logic                  ld_req_i,
  input  logic [`DC_ADDR_W-1:0] ld_addr_i,
  input  logic [`DC_XLEN/8-1:0] ld_be_i,
  input  logic [1:0]            ld_size_i,
  input  logic [`DC_TID_W-1:0]  ld_id_i,
  input  logic                  ld_kill_i,
  output logic                  ld_gnt_o,
  output logic                  ld_rvalid_o,
  output logic [`DC_XLEN-1:0]   ld_rdata_o,
  output logic [`DC_TID_W-1:0]  ld_rid_o,
  // Store port
  input  logic                  st_req_i,
  input  logic [`DC_ADDR_W-1:0] st_addr_i,
  input  logic [`DC_XLEN-1:0]   st_wdata_i,
  input  logic [`DC_XLEN/8-1:0] st_be_i,
  input  logic [1:0]            st_size_i,
  output logic                  st_gnt_o,
  // AMO port
  input  logic                  amo_req_i,
  input  dc_pkg::core_amo_e     amo_op_i,
  input  logic [1:0]            amo_size_i,
  input  logic [`DC_XLEN-1:0]   amo_operand_a_i,
  input  logic [`DC_XLEN-1:0]   amo_operand_b_i,
  output logic                  amo_ack_o,
  output logic [`DC_XLEN-1:0]   amo_result_o
);

  dc_port_if ld_port ();
  dc_port_if st_port ();
  dc_port_if mem_port ();

  load_port_adapter i_load_adapter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_req_i    (ld_req_i),
    .core_addr_i   (ld_addr_i),
    .core_be_i     (ld_be_i),
    .core_size_i   (ld_size_i),
    .core_id_i     (ld_id_i),
    .core_kill_i   (ld_kill_i),
    .core_gnt_o    (ld_gnt_o),
    .core_rvalid_o (ld_rvalid_o),
    .core_rdata_o  (ld_rdata_o),
    .core_rid_o    (ld_rid_o),
    .cache         (ld_port)
  );

  store_amo_port_adapter i_store_amo_adapter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .st_req_i        (st_req_i),
    .st_addr_i       (st_addr_i),
    .st_wdata_i      (st_wdata_i),
    .st_be_i         (st_be_i),
    .st_size_i       (st_size_i),
    .st_gnt_o        (st_gnt_o),
    .amo_req_i       (amo_req_i),
    .amo_op_i        (amo_op_i),
    .amo_size_i      (amo_size_i),
    .amo_operand_a_i (amo_operand_a_i),
    .amo_operand_b_i (amo_operand_b_i),
    .amo_ack_o       (amo_ack_o),
    .amo_result_o    (amo_result_o),
    .cache           (st_port)
  );

  dc_port_arbiter i_arbiter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .hi     (st_port),
    .lo     (ld_port),
    .out    (mem_port)
  );

  dc_backend i_backend (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .port   (mem_port)
  );

endmodule

// File: dc_subsys_asserts.sv
`timescale 1ns/1ps

module dc_subsys_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic ld_kill_i,
  input logic ld_gnt_i,
  input logic ld_rvalid_i,
  input logic st_req_i,
  input logic st_gnt_i,
  input logic amo_req_i,
  input logic amo_ack_i
);

  // Core never mixes a store with an AMO
  st_amo_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(st_req_i && amo_req_i))
    else $error("store and AMO requested in the same cycle");

  // Store/AMO side holds off the load port
  ld_backpressure_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      st_req_i |-> !ld_gnt_i)
    else $error("load granted while a store was requested");

  ld_rvalid_after_gnt_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (ld_gnt_i && !ld_kill_i) |=> ld_rvalid_i)
    else $error("no load response one cycle after grant");

  ld_rvalid_cause_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ld_rvalid_i |-> $past(ld_gnt_i && !ld_kill_i))
    else $error("load response without a live grant one cycle before");

  amo_ack_timing_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(amo_req_i) |=> amo_ack_i)
    else $error("AMO ack not one cycle after the request");

  amo_ack_cause_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      amo_ack_i |-> $past(amo_req_i))
    else $error("AMO ack without a request");

  // Quiet outputs while in reset
  reset_quiet_a: assert property (@(posedge clk_i)
      !rst_ni |-> (!ld_gnt_i && !ld_rvalid_i && !st_gnt_i && !amo_ack_i))
    else $error("output active during reset");

endmodule

bind dc_subsys_top dc_subsys_asserts i_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .ld_kill_i   (ld_kill_i),
  .ld_gnt_i    (ld_gnt_o),
  .ld_rvalid_i (ld_rvalid_o),
  .st_req_i    (st_req_i),
  .st_gnt_i    (st_gnt_o),
  .amo_req_i   (amo_req_i),
  .amo_ack_i   (amo_ack_o)
);

// File: tb_dc_subsys.sv
`timescale 1ns/1ps
`include "dc_cfg.svh"

module tb_dc_subsys;

  localparam int Timeout = 20;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic        clk;
  logic        rst_n;
  logic        ld_req;
  logic [31:0] ld_addr;
  logic [7:0]  ld_be;
  logic [1:0]  ld_size;
  logic [3:0]  ld_id;
  logic        ld_kill;
  logic        ld_gnt;
  logic        ld_rvalid;
  logic [63:0] ld_rdata;
  logic [3:0]  ld_rid;
  logic        st_req;
  logic [31:0] st_addr;
  logic [63:0] st_wdata;
  logic [7:0]  st_be;
  logic [1:0]  st_size;
  logic        st_gnt;
  logic        amo_req;
  dc_pkg::core_amo_e amo_op;
  logic [1:0]  amo_size;
  logic [63:0] amo_operand_a;
  logic [63:0] amo_operand_b;
  logic        amo_ack;
  logic [63:0] amo_result;

  logic [31:0] lfsr;
  logic [63:0] ref_mem [64];
  logic        ref_resv_valid;
  logic [5:0]  ref_resv_idx;
  logic [31:0] st_addrs [8];

  dc_subsys_top i_dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .ld_req_i        (ld_req),
    .ld_addr_i       (ld_addr),
    .ld_be_i         (ld_be),
    .ld_size_i       (ld_size),
    .ld_id_i         (ld_id),
    .ld_kill_i       (ld_kill),
    .ld_gnt_o        (ld_gnt),
    .ld_rvalid_o     (ld_rvalid),
    .ld_rdata_o      (ld_rdata),
    .ld_rid_o        (ld_rid),
    .st_req_i        (st_req),
    .st_addr_i       (st_addr),
    .st_wdata_i      (st_wdata),
    .st_be_i         (st_be),
    .st_size_i       (st_size),
    .st_gnt_o        (st_gnt),
    .amo_req_i       (amo_req),
    .amo_op_i        (amo_op),
    .amo_size_i      (amo_size),
    .amo_operand_a_i (amo_operand_a),
    .amo_operand_b_i (amo_operand_b),
    .amo_ack_o       (amo_ack),
    .amo_result_o    (amo_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LfsrTaps) : (lfsr >> 1);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic wait_failed(input string what);
    $display("Timeout: no %s within %0d cycles", what, Timeout);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // Read-modify-write result of one AMO on two operands
  function automatic logic [63:0] rmw_value(input dc_pkg::core_amo_e op,
                                            input logic [63:0] a, input logic [63:0] b);
    case (op)
      dc_pkg::AMO_ADD:  return a + b;
      dc_pkg::AMO_AND:  return a & b;
      dc_pkg::AMO_OR:   return a | b;
      dc_pkg::AMO_XOR:  return a ^ b;
      dc_pkg::AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
      dc_pkg::AMO_MAXU: return (a > b) ? a : b;
      dc_pkg::AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      dc_pkg::AMO_MINU: return (a < b) ? a : b;
      default:          return b;
    endcase
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] be);
    logic [63:0] mask;
    for (int i = 0; i < 8; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    ref_mem[addr[8:3]] = (ref_mem[addr[8:3]] & ~mask) | (data & mask);
    if (addr[8:3] == ref_resv_idx) begin
      ref_resv_valid = 1'b0;
    end
  endtask

  task automatic model_amo(input dc_pkg::core_amo_e op, input logic [1:0] size,
                           input logic [31:0] addr, input logic [63:0] operand,
                           output logic [63:0] result);
    logic [63:0] old;
    logic [31:0] old_half;
    logic        word;
    logic [7:0]  be;
    logic [63:0] upd;
    logic        sc_ok;
    old      = ref_mem[addr[8:3]];
    word     = (size == 2'b10);
    old_half = addr[2] ? old[63:32] : old[31:0];
    be       = word ? (addr[2] ? 8'hf0 : 8'h0f) : 8'hff;
    result   = word ? {{32{old_half[31]}}, old_half} : old;
    if (op == dc_pkg::AMO_LR) begin
      ref_resv_valid = (addr < (`DC_CACHEABLE_BASE + `DC_CACHEABLE_SIZE));
      ref_resv_idx   = addr[8:3];
    end else if (op == dc_pkg::AMO_SC) begin
      sc_ok  = ref_resv_valid && (ref_resv_idx == addr[8:3]);
      result = sc_ok ? 64'd0 : 64'd1;
      if (sc_ok) begin
        model_write(addr, word ? {2{operand[31:0]}} : operand, be);
      end
      ref_resv_valid = 1'b0;
    end else if (word) begin
      // Word operands in the upper half keep sums and compares 32-bit
      upd = rmw_value(op, {old_half, 32'b0}, {operand[31:0], 32'b0});
      model_write(addr, {2{upd[63:32]}}, be);
    end else begin
      model_write(addr, rmw_value(op, old, operand), be);
    end
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] be);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #5;
    st_req   = 1'b1;
    st_addr  = addr;
    st_wdata = data;
    st_be    = be;
    st_size  = 2'b11;
    @(negedge clk);
    while (!st_gnt) begin
      if (cycles == Timeout) begin
        wait_failed("store grant");
      end
      cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    #5;
    st_req = 1'b0;
    model_write(addr, data, be);
  endtask

  task automatic start_load(input logic [31:0] addr, input logic [3:0] id,
                            input logic kill);
    @(posedge clk);
    #5;
    ld_req  = 1'b1;
    ld_addr = addr;
    ld_id   = id;
    ld_kill = kill;
  endtask

  // Waits for the grant of the pending load, then checks its response
  task automatic complete_load();
    int          cycles;
    logic        kill;
    logic [3:0]  id;
    logic [63:0] expected;
    cycles = 0;
    kill   = ld_kill;
    id     = ld_id;
    @(negedge clk);
    while (!ld_gnt) begin
      if (cycles == Timeout) begin
        wait_failed("load grant");
      end
      cycles++;
      @(negedge clk);
    end
    expected = ref_mem[ld_addr[8:3]];
    @(posedge clk);
    #5;
    ld_req  = 1'b0;
    ld_kill = 1'b0;
    @(negedge clk);
    check_value("ld_rvalid_o", 64'(!kill), 64'(ld_rvalid));
    if (!kill) begin
      check_value("ld_rdata_o", expected, ld_rdata);
      check_value("ld_rid_o", 64'(id), 64'(ld_rid));
    end
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [3:0] id,
                           input logic kill);
    start_load(addr, id, kill);
    complete_load();
  endtask

  task automatic run_amo(input dc_pkg::core_amo_e op, input logic [1:0] size,
                         input logic [31:0] addr, input logic [63:0] operand);
    int          cycles;
    logic [63:0] expected;
    model_amo(op, size, addr, operand, expected);
    @(posedge clk);
    #5;
    amo_req       = 1'b1;
    amo_op        = op;
    amo_size      = size;
    amo_operand_a = {32'b0, addr};
    amo_operand_b = operand;
    @(posedge clk);
    #5;
    cycles = 1;
    while (!amo_ack) begin
      if (cycles == Timeout) begin
        wait_failed("AMO acknowledge");
      end
      cycles++;
      @(posedge clk);
      #5;
    end
    amo_req = 1'b0;
    check_value("amo_ack_o latency", 64'd1, 64'(cycles));
    check_value("amo_result_o", expected, amo_result);
  endtask

  initial begin
    logic [31:0]       addr;
    logic [63:0]       data;
    logic [1:0]        size;
    dc_pkg::core_amo_e op;
    lfsr          = 32'd10;
    rst_n         = 1'b0;
    ld_req        = 1'b0;
    ld_addr       = '0;
    ld_be         = 8'hff;
    ld_size       = 2'b11;
    ld_id         = '0;
    ld_kill       = 1'b0;
    st_req        = 1'b0;
    st_addr       = '0;
    st_wdata      = '0;
    st_be         = '0;
    st_size       = 2'b11;
    amo_req       = 1'b0;
    amo_op        = dc_pkg::AMO_NONE;
    amo_size      = 2'b11;
    amo_operand_a = '0;
    amo_operand_b = '0;
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = '0;
    end
    ref_resv_valid = 1'b0;
    ref_resv_idx   = '0;
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // Random stores with random byte enables, then read back
    for (int i = 0; i < 8; i++) begin
      st_addrs[i] = {23'b0, 6'(random_bits(6)), 3'b000};
      store_word(st_addrs[i], random_bits(64), 8'(random_bits(8)));
    end
    for (int i = 0; i < 8; i++) begin
      load_word(st_addrs[i], 4'(random_bits(4)), 1'b0);
    end

    // Load and store in the same cycle, the store goes first
    addr = st_addrs[0];
    data = random_bits(64);
    @(posedge clk);
    #5;
    st_req   = 1'b1;
    st_addr  = addr;
    st_wdata = data;
    st_be    = 8'hff;
    ld_req   = 1'b1;
    ld_addr  = addr;
    ld_id    = 4'h5;
    ld_kill  = 1'b0;
    @(negedge clk);
    check_value("st_gnt_o", 64'd1, 64'(st_gnt));
    check_value("ld_gnt_o", 64'd0, 64'(ld_gnt));
    @(posedge clk);
    #5;
    st_req = 1'b0;
    model_write(addr, data, 8'hff);
    complete_load();

    // Killed load, then a normal one
    load_word(st_addrs[1], 4'h3, 1'b1);
    load_word(st_addrs[1], 4'h4, 1'b0);

    // Nine RMW AMOs as doubleword, low word and high word
    for (int k = 3; k <= 11; k++) begin
      op = dc_pkg::core_amo_e'(k[3:0]);
      for (int form = 0; form < 3; form++) begin
        addr = {24'b0, 5'(random_bits(5)), (form == 2), 2'b00};
        size = (form == 0) ? 2'b11 : 2'b10;
        store_word({addr[31:3], 3'b000}, random_bits(64), 8'hff);
        run_amo(op, size, addr, random_bits(64));
        load_word(addr, 4'(random_bits(4)), 1'b0);
      end
    end

    // LR/SC pair on a cacheable word, then a second SC
    addr = 32'h0000_0040;
    data = random_bits(64);
    run_amo(dc_pkg::AMO_LR, 2'b11, addr, 64'd0);
    run_amo(dc_pkg::AMO_SC, 2'b11, addr, data);
    load_word(addr, 4'h1, 1'b0);
    run_amo(dc_pkg::AMO_SC, 2'b11, addr, ~data);
    load_word(addr, 4'h2, 1'b0);

    // Uncacheable LR leaves no reservation
    addr = 32'h0000_0148;
    run_amo(dc_pkg::AMO_LR, 2'b11, addr, 64'd0);
    run_amo(dc_pkg::AMO_SC, 2'b11, addr, random_bits(64));
    load_word(addr, 4'h6, 1'b0);

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+.
dc_pkg.sv
dc_port_if.sv
load_port_adapter.sv
store_amo_port_adapter.sv
dc_port_arbiter.sv
dc_backend.sv
dc_subsys_top.sv
dc_subsys_asserts.sv
tb_dc_subsys.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_dc_subsys -f flist.f
./obj_dir/Vtb_dc_subsys
